//--- run.sh
#!/usr/bin/env bash
# Build and run the VLSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vlsu_tb -f vlsu.f -o vlsu_sim \
  && ./obj_dir/vlsu_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

exit 0

//--- source/vlsu.sv
// Vector load/store unit top
`timescale 1ns/100ps

module vlsu (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  // Sequencer
  input  vlsu_pkg::vlsu_req_t                             pe_req_i,
  input  logic                                            pe_req_valid_i,
  output logic                                            pe_req_ready_o,
  output logic                                            addrgen_ack_o,
  output logic                                            load_complete_o,
  output logic                                            store_complete_o,
  output vlsu_pkg::id_t                                   complete_id_o,
  output logic                                            store_pending_o,
  // Memory request channel
  output vlsu_pkg::mem_req_t                              mem_req_o,
  output logic                                            mem_req_valid_o,
  input  logic                                            mem_req_ready_i,
  // Read data channel
  input  vlsu_pkg::mem_data_t                             mem_rdata_i,
  input  logic                                            mem_rvalid_i,
  output logic                                            mem_rready_o,
  // Write data channel
  output vlsu_pkg::mem_wbeat_t                            mem_w_o,
  output logic                                            mem_w_valid_o,
  input  logic                                            mem_w_ready_i,
  // Lanes
  input  vlsu_pkg::elen_t        [vlsu_pkg::NR_LANES-1:0] stu_operand_i,
  input  logic                   [vlsu_pkg::NR_LANES-1:0] stu_operand_valid_i,
  output logic                   [vlsu_pkg::NR_LANES-1:0] stu_operand_ready_o,
  output vlsu_pkg::lane_result_t [vlsu_pkg::NR_LANES-1:0] ldu_result_o,
  output logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_valid_o,
  input  logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_gnt_i
);

  vlsu_pkg::beat_t     beat;
  vlsu_pkg::beat_t     ld_beat;
  vlsu_pkg::beat_t     st_beat;
  logic                ld_beat_push;
  logic                st_beat_push;
  logic                ld_beat_full;
  logic                st_beat_full;
  logic                ld_beat_pop;
  logic                st_beat_pop;
  logic                ld_beat_empty;
  logic                st_beat_empty;
  vlsu_pkg::mem_data_t rdata;
  logic                rdata_full;
  logic                rdata_empty;
  logic                rdata_pop;
  vlsu_pkg::id_t       load_id;
  vlsu_pkg::id_t       store_id;

  assign mem_rready_o  = ~rdata_full;
  // Loads and stores never finish in the same cycle
  assign complete_id_o = store_complete_o ? store_id : load_id;

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  vlsu_addrgen i_addrgen (
    .clk_i,
    .arst_n_i,
    .pe_req_i,
    .pe_req_valid_i,
    .pe_req_ready_o,
    .addrgen_ack_o,
    .mem_req_o,
    .mem_req_valid_o,
    .mem_req_ready_i,
    .ld_beat_full_i  (ld_beat_full),
    .st_beat_full_i  (st_beat_full),
    .beat_o          (beat),
    .ld_beat_push_o  (ld_beat_push),
    .st_beat_push_o  (st_beat_push)
  );

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  vlsu_queue #(
    .payload_t (vlsu_pkg::beat_t),
    .DEPTH     (vlsu_pkg::BEAT_QUEUE_DEPTH)
  ) i_ld_beat_queue (
    .clk_i,
    .arst_n_i,
    .push_i   (ld_beat_push),
    .data_i   (beat),
    .full_o   (ld_beat_full),
    .pop_i    (ld_beat_pop),
    .data_o   (ld_beat),
    .empty_o  (ld_beat_empty)
  );

  vlsu_queue #(
    .payload_t (vlsu_pkg::beat_t),
    .DEPTH     (vlsu_pkg::BEAT_QUEUE_DEPTH)
  ) i_st_beat_queue (
    .clk_i,
    .arst_n_i,
    .push_i   (st_beat_push),
    .data_i   (beat),
    .full_o   (st_beat_full),
    .pop_i    (st_beat_pop),
    .data_o   (st_beat),
    .empty_o  (st_beat_empty)
  );

  vlsu_queue #(
    .payload_t (vlsu_pkg::mem_data_t),
    .DEPTH     (vlsu_pkg::LOAD_DATA_DEPTH)
  ) i_rdata_queue (
    .clk_i,
    .arst_n_i,
    .push_i   (mem_rvalid_i & mem_rready_o),
    .data_i   (mem_rdata_i),
    .full_o   (rdata_full),
    .pop_i    (rdata_pop),
    .data_o   (rdata),
    .empty_o  (rdata_empty)
  );

  //////////////////////////////////////////////////
  // Load and store units
  //////////////////////////////////////////////////

  vlsu_load_unit i_load_unit (
    .clk_i,
    .arst_n_i,
    .beat_i             (ld_beat),
    .beat_empty_i       (ld_beat_empty),
    .beat_pop_o         (ld_beat_pop),
    .rdata_i            (rdata),
    .rdata_empty_i      (rdata_empty),
    .rdata_pop_o        (rdata_pop),
    .ldu_result_o,
    .ldu_result_valid_o,
    .ldu_result_gnt_i,
    .load_complete_o,
    .load_id_o          (load_id)
  );

  vlsu_store_unit i_store_unit (
    .clk_i,
    .arst_n_i,
    .beat_i              (st_beat),
    .beat_empty_i        (st_beat_empty),
    .beat_pop_o          (st_beat_pop),
    .stu_operand_i,
    .stu_operand_valid_i,
    .stu_operand_ready_o,
    .mem_w_o,
    .mem_w_valid_o,
    .mem_w_ready_i,
    .store_complete_o,
    .store_id_o          (store_id),
    .store_pending_o
  );

endmodule

//--- source/vlsu_addrgen.sv
// Beat address generator
`timescale 1ns/100ps

module vlsu_addrgen (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Sequencer
  input  vlsu_pkg::vlsu_req_t pe_req_i,
  input  logic                pe_req_valid_i,
  output logic                pe_req_ready_o,
  output logic                addrgen_ack_o,
  // Memory request channel
  output vlsu_pkg::mem_req_t  mem_req_o,
  output logic                mem_req_valid_o,
  input  logic                mem_req_ready_i,
  // Beat descriptor queues
  input  logic                ld_beat_full_i,
  input  logic                st_beat_full_i,
  output vlsu_pkg::beat_t     beat_o,
  output logic                ld_beat_push_o,
  output logic                st_beat_push_o
);

  vlsu_pkg::vlsu_req_t req_q;
  logic                busy_q;
  vlsu_pkg::vl_t       remaining_q;
  vlsu_pkg::vrf_addr_t beat_cnt_q;

  logic pe_fire;
  logic req_fire;
  logic queue_full;

  assign pe_req_ready_o = ~busy_q;
  assign pe_fire        = pe_req_valid_i & pe_req_ready_o;

  // Hold the request back while its descriptor queue is full
  assign queue_full      = req_q.is_store ? st_beat_full_i : ld_beat_full_i;
  assign mem_req_valid_o = busy_q & ~queue_full;
  assign req_fire        = mem_req_valid_o & mem_req_ready_i;

  //////////////////////////////////////////////////
  // Beat request and descriptor
  //////////////////////////////////////////////////

  assign mem_req_o.addr = req_q.addr +
                          (vlsu_pkg::addr_t'(beat_cnt_q) << vlsu_pkg::BEAT_SHIFT);
  assign mem_req_o.we   = req_q.is_store;

  always_comb begin
    beat_o.id   = req_q.id;
    beat_o.beat = beat_cnt_q;
    beat_o.last = remaining_q <= vlsu_pkg::vl_t'(vlsu_pkg::NR_LANES);
    // Lane k holds an element while more than k remain
    for (int unsigned k = 0; k < vlsu_pkg::NR_LANES; k++) begin
      beat_o.lane_active[k] = remaining_q > vlsu_pkg::vl_t'(k);
    end
  end

  assign ld_beat_push_o = req_fire & ~req_q.is_store;
  assign st_beat_push_o = req_fire &  req_q.is_store;
  assign addrgen_ack_o  = req_fire & beat_o.last;

  //////////////////////////////////////////////////
  // Instruction state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      remaining_q <= '0;
      beat_cnt_q  <= '0;
    end else if (pe_fire) begin
      busy_q      <= 1'b1;
      remaining_q <= pe_req_i.vl;
      beat_cnt_q  <= '0;
    end else if (req_fire) begin
      busy_q      <= ~beat_o.last;
      remaining_q <= remaining_q - vlsu_pkg::vl_t'(vlsu_pkg::NR_LANES);
      beat_cnt_q  <= beat_cnt_q + vlsu_pkg::vrf_addr_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_fire) begin
      req_q <= pe_req_i;
    end
  end

  // Every unit-stride beat must map onto one memory word
  a_base_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pe_fire |-> pe_req_i.addr[vlsu_pkg::BEAT_SHIFT-1:0] == '0)
    else $error("vlsu_addrgen: base address not 16-byte aligned");

endmodule

//--- source/vlsu_load_unit.sv
// Vector load unit
`timescale 1ns/100ps

module vlsu_load_unit (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  // Load beat descriptors
  input  vlsu_pkg::beat_t                                 beat_i,
  input  logic                                            beat_empty_i,
  output logic                                            beat_pop_o,
  // Read data queue
  input  vlsu_pkg::mem_data_t                             rdata_i,
  input  logic                                            rdata_empty_i,
  output logic                                            rdata_pop_o,
  // Lanes
  output vlsu_pkg::lane_result_t [vlsu_pkg::NR_LANES-1:0] ldu_result_o,
  output logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_valid_o,
  input  logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_gnt_i,
  // Completion
  output logic                                            load_complete_o,
  output vlsu_pkg::id_t                                   load_id_o
);

  // A beat is on offer to the lanes
  logic                          active_q;
  logic [vlsu_pkg::NR_LANES-1:0] granted_q;

  logic all_granted;
  logic retire;

  //////////////////////////////////////////////////
  // Lane results
  //////////////////////////////////////////////////

  // Both heads stay put until retire, so they carry the result payload
  always_comb begin
    for (int unsigned k = 0; k < vlsu_pkg::NR_LANES; k++) begin
      ldu_result_o[k].id    = beat_i.id;
      ldu_result_o[k].addr  = beat_i.beat;
      ldu_result_o[k].wdata = rdata_i[k*vlsu_pkg::ELEN +: vlsu_pkg::ELEN];
    end
  end

  assign ldu_result_valid_o = {vlsu_pkg::NR_LANES{active_q}} & beat_i.lane_active &
                              ~granted_q;

  // Inactive lanes count as done
  assign all_granted = &(granted_q | ~beat_i.lane_active);
  assign retire      = active_q & all_granted;

  assign beat_pop_o      = retire;
  assign rdata_pop_o     = retire;
  assign load_complete_o = retire & beat_i.last;
  assign load_id_o       = beat_i.id;

  //////////////////////////////////////////////////
  // Beat state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q  <= 1'b0;
      granted_q <= '0;
    end else if (retire) begin
      active_q  <= 1'b0;
      granted_q <= '0;
    end else if (active_q) begin
      // Lanes may accept in different cycles
      granted_q <= granted_q | (ldu_result_gnt_i & ldu_result_valid_o);
    end else if (!beat_empty_i && !rdata_empty_i) begin
      active_q <= 1'b1;
    end
  end

  a_gnt_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ldu_result_gnt_i & ~ldu_result_valid_o) == '0)
    else $error("vlsu_load_unit: lane grant without a valid result");

endmodule

//--- source/vlsu_pkg.sv
// Vector load/store unit definitions
package vlsu_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NR_LANES   = 2;
  localparam int unsigned ELEN       = 64;
  localparam int unsigned ELEN_BYTES = ELEN / 8;
  localparam int unsigned MEM_DATA_W = NR_LANES * ELEN;
  localparam int unsigned MEM_STRB_W = MEM_DATA_W / 8;
  // log2 of the beat size in bytes
  localparam int unsigned BEAT_SHIFT = $clog2(MEM_STRB_W);
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned VL_W       = 8;
  localparam int unsigned ID_W       = 3;
  localparam int unsigned VRF_ADDR_W = 7;

  // Queue depths
  localparam int unsigned BEAT_QUEUE_DEPTH = 4;
  localparam int unsigned LOAD_DATA_DEPTH  = 2;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [VL_W-1:0]       vl_t;
  typedef logic [ID_W-1:0]       id_t;
  typedef logic [VRF_ADDR_W-1:0] vrf_addr_t;
  typedef logic [ELEN-1:0]       elen_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;

  // Instruction from the sequencer
  typedef struct packed {
    logic  is_store;
    addr_t addr;
    vl_t   vl;
    id_t   id;
  } vlsu_req_t;

  // One request per 128-bit beat
  typedef struct packed {
    addr_t addr;
    logic  we;
  } mem_req_t;

  // Beat number of a descriptor doubles as VRF index
  typedef struct packed {
    id_t                 id;
    vrf_addr_t           beat;
    logic [NR_LANES-1:0] lane_active;
    logic                last;
  } beat_t;

  typedef struct packed {
    id_t       id;
    vrf_addr_t addr;
    elen_t     wdata;
  } lane_result_t;

  typedef struct packed {
    mem_data_t             data;
    logic [MEM_STRB_W-1:0] strb;
  } mem_wbeat_t;

endpackage

//--- source/vlsu_queue.sv
// Small circular FIFO
`timescale 1ns/100ps

module vlsu_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem_q [DEPTH];
  ptr_t     rd_ptr_q;
  ptr_t     wr_ptr_q;
  cnt_t     count_q;

  assign full_o  = count_q == cnt_t'(DEPTH);
  assign empty_o = count_q == '0;
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Producers watch full, consumers watch empty
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o) && !(pop_i && empty_o))
    else $error("vlsu_queue: push while full or pop while empty");

endmodule

//--- source/vlsu_store_unit.sv
// Vector store unit
`timescale 1ns/100ps

module vlsu_store_unit (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Store beat descriptors
  input  vlsu_pkg::beat_t                          beat_i,
  input  logic                                     beat_empty_i,
  output logic                                     beat_pop_o,
  // Lane operands
  input  vlsu_pkg::elen_t [vlsu_pkg::NR_LANES-1:0] stu_operand_i,
  input  logic            [vlsu_pkg::NR_LANES-1:0] stu_operand_valid_i,
  output logic            [vlsu_pkg::NR_LANES-1:0] stu_operand_ready_o,
  // Write data channel
  output vlsu_pkg::mem_wbeat_t                     mem_w_o,
  output logic                                     mem_w_valid_o,
  input  logic                                     mem_w_ready_i,
  // Completion
  output logic                                     store_complete_o,
  output vlsu_pkg::id_t                            store_id_o,
  output logic                                     store_pending_o
);

  logic                 w_valid_q;
  vlsu_pkg::mem_wbeat_t w_beat_q;
  vlsu_pkg::mem_wbeat_t w_beat_d;

  logic operands_ok;
  logic load_beat;
  logic w_fire;

  assign operands_ok = &(stu_operand_valid_i | ~beat_i.lane_active);
  assign load_beat   = ~w_valid_q & ~beat_empty_i & operands_ok;
  assign w_fire      = w_valid_q & mem_w_ready_i;

  //////////////////////////////////////////////////
  // Write beat assembly
  //////////////////////////////////////////////////

  always_comb begin
    for (int unsigned k = 0; k < vlsu_pkg::NR_LANES; k++) begin
      w_beat_d.data[k*vlsu_pkg::ELEN +: vlsu_pkg::ELEN] = stu_operand_i[k];
      // Bytes past vl keep their old memory contents
      w_beat_d.strb[k*vlsu_pkg::ELEN_BYTES +: vlsu_pkg::ELEN_BYTES] =
        {vlsu_pkg::ELEN_BYTES{beat_i.lane_active[k]}};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_valid_q <= 1'b0;
    end else if (w_fire) begin
      w_valid_q <= 1'b0;
    end else if (load_beat) begin
      w_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_beat) begin
      w_beat_q <= w_beat_d;
    end
  end

  assign mem_w_o       = w_beat_q;
  assign mem_w_valid_o = w_valid_q;

  // Operands and descriptor leave together with the beat
  assign stu_operand_ready_o = {vlsu_pkg::NR_LANES{w_fire}} & beat_i.lane_active;
  assign beat_pop_o          = w_fire;

  assign store_complete_o = w_fire & beat_i.last;
  assign store_id_o       = beat_i.id;
  assign store_pending_o  = ~beat_empty_i | w_valid_q;

endmodule

//--- testbench/vlsu_tb.sv
// Vector load/store unit testbench
`timescale 1ns/100ps

module vlsu_tb;

  localparam int unsigned MEM_WORDS  = 64;
  localparam int unsigned MAX_CYCLES = 4000;

  logic                                            clk_i               = 1'b0;
  logic                                            arst_n_i            = 1'b0;
  vlsu_pkg::vlsu_req_t                             pe_req_i            = '0;
  logic                                            pe_req_valid_i      = 1'b0;
  logic                                            mem_req_ready_i     = 1'b0;
  vlsu_pkg::mem_data_t                             mem_rdata_i         = '0;
  logic                                            mem_rvalid_i        = 1'b0;
  logic                                            mem_w_ready_i       = 1'b0;
  vlsu_pkg::elen_t        [vlsu_pkg::NR_LANES-1:0] stu_operand_i       = '0;
  logic                   [vlsu_pkg::NR_LANES-1:0] stu_operand_valid_i = '0;
  logic                   [vlsu_pkg::NR_LANES-1:0] gnt_mask            = '0;
  logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_gnt_i;
  logic                                            pe_req_ready_o;
  logic                                            addrgen_ack_o;
  logic                                            load_complete_o;
  logic                                            store_complete_o;
  vlsu_pkg::id_t                                   complete_id_o;
  logic                                            store_pending_o;
  vlsu_pkg::mem_req_t                              mem_req_o;
  logic                                            mem_req_valid_o;
  logic                                            mem_rready_o;
  vlsu_pkg::mem_wbeat_t                            mem_w_o;
  logic                                            mem_w_valid_o;
  logic                   [vlsu_pkg::NR_LANES-1:0] stu_operand_ready_o;
  vlsu_pkg::lane_result_t [vlsu_pkg::NR_LANES-1:0] ldu_result_o;
  logic                   [vlsu_pkg::NR_LANES-1:0] ldu_result_valid_o;

  // Memory model state and expected image
  vlsu_pkg::mem_data_t mem [MEM_WORDS];
  vlsu_pkg::mem_data_t ref_mem [MEM_WORDS];
  vlsu_pkg::addr_t     raddr_q [$];
  vlsu_pkg::addr_t     waddr_q [$];
  int unsigned         written_q [$];
  vlsu_pkg::elen_t     op_q [vlsu_pkg::NR_LANES][$];
  vlsu_pkg::id_t       ld_id_q [$];
  vlsu_pkg::id_t       st_id_q [$];
  vlsu_pkg::vlsu_req_t req_of_id [1 << vlsu_pkg::ID_W];
  int unsigned         lane_cnt [vlsu_pkg::NR_LANES];
  int unsigned         res_cnt, ld_done, st_done, ack_cnt, cycles;
  int                  errors, tests_run, tests_failed;
  int                  seed   = 24318;
  logic                stress = 1'b0;

  vlsu dut0 (.*);

  // Lanes only grant what is on offer
  assign ldu_result_gnt_i = ldu_result_valid_o & gnt_mask;

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic coin();
    if (!stress) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic int unsigned word_of(input vlsu_pkg::addr_t a);
    if (a >= vlsu_pkg::addr_t'(MEM_WORDS * vlsu_pkg::MEM_STRB_W)) begin
      $display("Address %h lies outside the memory model", a);
      errors++;
    end
    return (a / vlsu_pkg::MEM_STRB_W) % MEM_WORDS;
  endfunction

  // Expected lane write for element e of a load
  function automatic vlsu_pkg::lane_result_t ref_result(input vlsu_pkg::vlsu_req_t req,
                                                        input int unsigned e);
    vlsu_pkg::lane_result_t res;
    vlsu_pkg::mem_data_t    word;
    word      = ref_mem[word_of(req.addr) + e / vlsu_pkg::NR_LANES];
    res.id    = req.id;
    res.addr  = vlsu_pkg::vrf_addr_t'(e / vlsu_pkg::NR_LANES);
    res.wdata = word[(e % vlsu_pkg::NR_LANES) * vlsu_pkg::ELEN +: vlsu_pkg::ELEN];
    return res;
  endfunction

  task automatic check(input string name, input logic [143:0] exp_v, input logic [143:0] act_v);
    if (exp_v !== act_v) begin
      $display("error %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic issue(input logic is_store, input vlsu_pkg::addr_t base, input int unsigned vl,
                       input vlsu_pkg::id_t id);
    vlsu_pkg::vlsu_req_t req;
    vlsu_pkg::elen_t     op;
    int unsigned         w;
    req.is_store  = is_store;
    req.addr      = base;
    req.vl        = vlsu_pkg::vl_t'(vl);
    req.id        = id;
    req_of_id[id] = req;
    if (is_store) begin
      for (int unsigned e = 0; e < vl; e++) begin
        op = {8'h57, 5'd0, id, 16'(e), base + 32'(vlsu_pkg::ELEN_BYTES * e)};
        op_q[e % vlsu_pkg::NR_LANES].push_back(op);
        w = word_of(base) + e / vlsu_pkg::NR_LANES;
        ref_mem[w][(e % vlsu_pkg::NR_LANES) * vlsu_pkg::ELEN +: vlsu_pkg::ELEN] = op;
      end
      st_id_q.push_back(id);
    end else begin
      ld_id_q.push_back(id);
    end
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    do @(posedge clk_i); while (!pe_req_ready_o);
    pe_req_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    while (ld_id_q.size() != 0 || st_id_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic compare_memory();
    for (int unsigned w = 0; w < MEM_WORDS; w++) begin
      check($sformatf("mem[%0d]", w), ref_mem[w], mem[w]);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("Test %s failed", name);
    end else begin
      $display("Test %s passed", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Memory, lanes and compare
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int unsigned w;
    mem_req_ready_i <= coin();
    mem_w_ready_i   <= coin();
    if (mem_req_valid_o && mem_req_ready_i) begin
      if (mem_req_o.we) begin
        waddr_q.push_back(mem_req_o.addr);
      end else begin
        raddr_q.push_back(mem_req_o.addr);
      end
    end
    if (mem_w_valid_o && mem_w_ready_i) begin
      if (waddr_q.size() == 0) begin
        $display("Write beat arrived without a write request");
        errors++;
      end else begin
        w = word_of(waddr_q.pop_front());
        for (int b = 0; b < vlsu_pkg::MEM_STRB_W; b++) begin
          if (mem_w_o.strb[b]) begin
            mem[w][b*8 +: 8] = mem_w_o.data[b*8 +: 8];
          end
        end
        written_q.push_back(w);
      end
    end
    // Read data returns in request order and is held until taken
    if (!mem_rvalid_i || mem_rready_o) begin
      if (raddr_q.size() != 0 && coin()) begin
        mem_rdata_i  <= mem[word_of(raddr_q.pop_front())];
        mem_rvalid_i <= 1'b1;
      end else begin
        mem_rvalid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    for (int k = 0; k < vlsu_pkg::NR_LANES; k++) begin
      gnt_mask[k] <= coin();
      if (stu_operand_valid_i[k] && stu_operand_ready_o[k]) begin
        void'(op_q[k].pop_front());
      end
      if (!stu_operand_valid_i[k] || stu_operand_ready_o[k]) begin
        if (op_q[k].size() != 0 && coin()) begin
          stu_operand_valid_i[k] <= 1'b1;
          stu_operand_i[k]       <= op_q[k][0];
        end else begin
          stu_operand_valid_i[k] <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    vlsu_pkg::lane_result_t exp_res;
    for (int k = 0; k < vlsu_pkg::NR_LANES; k++) begin
      if (ldu_result_valid_o[k] && ldu_result_gnt_i[k]) begin
        if (ld_id_q.size() == 0) begin
          $display("Lane %0d got a load result with no load outstanding", k);
          errors++;
        end else begin
          exp_res = ref_result(req_of_id[ld_id_q[0]], 2 * lane_cnt[k] + k);
          check($sformatf("ldu_result_o[%0d]", k), exp_res, ldu_result_o[k]);
        end
        lane_cnt[k]++;
        res_cnt++;
      end
    end
    if (load_complete_o) begin
      if (ld_id_q.size() == 0) begin
        $display("load_complete_o pulsed with no load outstanding");
        errors++;
      end else begin
        check("complete_id_o", ld_id_q[0], complete_id_o);
        check("load result count", req_of_id[ld_id_q[0]].vl, res_cnt);
        void'(ld_id_q.pop_front());
      end
      lane_cnt = '{default: 0};
      res_cnt  = 0;
      ld_done++;
    end
    if (store_complete_o) begin
      // The last write is still outstanding during its handshake
      check("store_pending_o", 1, store_pending_o);
      if (st_id_q.size() == 0) begin
        $display("store_complete_o pulsed with no store outstanding");
        errors++;
      end else begin
        check("complete_id_o", st_id_q[0], complete_id_o);
        void'(st_id_q.pop_front());
      end
      st_done++;
    end
    if (addrgen_ack_o) begin
      ack_cnt++;
    end
    while (written_q.size() != 0) begin
      check("written word", ref_mem[written_q[0]], mem[written_q[0]]);
      void'(written_q.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    int          e0;
    int unsigned d_ld;
    int unsigned d_st;
    int unsigned d_ack;
    for (int unsigned w = 0; w < MEM_WORDS; w++) begin
      mem[w]     = {32'hA5A5_0001, 32'(w * 16 + 8), 32'hA5A5_0000, 32'(w * 16)};
      ref_mem[w] = mem[w];
    end
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);

    e0 = errors;
    check("mem_req_valid_o", 0, mem_req_valid_o);
    check("mem_w_valid_o", 0, mem_w_valid_o);
    check("ldu_result_valid_o", 0, ldu_result_valid_o);
    check("load_complete_o", 0, load_complete_o);
    check("store_complete_o", 0, store_complete_o);
    check("addrgen_ack_o", 0, addrgen_ack_o);
    check("store_pending_o", 0, store_pending_o);
    check("pe_req_ready_o", 1, pe_req_ready_o);
    end_test("reset state", e0);

    e0   = errors;
    d_ld = ld_done;
    issue(1'b0, 32'h000, 8, 3'd1);
    wait_idle();
    check("load completions", 1, ld_done - d_ld);
    end_test("load even vl", e0);

    e0   = errors;
    d_ld = ld_done;
    issue(1'b0, 32'h040, 5, 3'd2);
    wait_idle();
    check("load completions", 1, ld_done - d_ld);
    end_test("load odd vl", e0);

    e0   = errors;
    d_st = st_done;
    issue(1'b1, 32'h200, 5, 3'd3);
    wait_idle();
    check("store completions", 1, st_done - d_st);
    check("store_pending_o", 0, store_pending_o);
    compare_memory();
    end_test("store odd vl", e0);

    // Loads and stores share complete_id_o so a change of kind waits for the other unit
    e0     = errors;
    d_ld   = ld_done;
    d_st   = st_done;
    d_ack  = ack_cnt;
    stress = 1'b1;
    issue(1'b0, 32'h080, 12, 3'd4);
    issue(1'b0, 32'h100, 7, 3'd5);
    wait_idle();
    issue(1'b1, 32'h280, 9, 3'd6);
    issue(1'b1, 32'h300, 6, 3'd7);
    wait_idle();
    issue(1'b0, 32'h140, 3, 3'd0);
    wait_idle();
    check("load completions", 3, ld_done - d_ld);
    check("store completions", 2, st_done - d_st);
    check("addrgen_ack_o count", 5, ack_cnt - d_ack);
    check("store_pending_o", 0, store_pending_o);
    compare_memory();
    end_test("back-pressure", e0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- vlsu.f
source/vlsu_pkg.sv
source/vlsu_queue.sv
source/vlsu_addrgen.sv
source/vlsu_load_unit.sv
source/vlsu_store_unit.sv
source/vlsu.sv
testbench/vlsu_tb.sv
